// File: tb.f
+incdir+logic
+incdir+verif
logic/dec_pkg.sv
logic/ctrl_decode.sv
logic/imm_gen.sv
logic/reg_file.sv
logic/decode_stage.sv
verif/dec_tb.sv

// File: verif/dec_tb_table.svh
// decode test vectors
// instruction word, pc, expected control fields, immediate and operand swap
`ifndef DEC_TB_TABLE_SVH
`define DEC_TB_TABLE_SVH

typedef struct packed {
	logic [31:0] word;
	logic [31:0] pc;
	alu_op_e     alu_op;
	opnd_sel_e   opnd_sel;
	br_cond_e    br_cond;
	mem_req_e    mem_req;
	ld_ext_e     ld_ext;
	logic        reg_we;
	logic [31:0] imm;
	logic        swap; // src1 and src2 exchanged
} row_t;

localparam int NROWS = 26;

// word, pc, alu, sel, br, mem, ext, we, imm, swap
row_t rows [NROWS] = '{
	// arithmetic, add sub sra srl and, then addi srai xori
	'{32'h002081b3, 32'h1000, ALU_ADD, SEL_REG_REG, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h0, 1'b0},
	'{32'h407302b3, 32'h1004, ALU_SUB, SEL_REG_REG, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h0, 1'b0},
	'{32'h40a4d433, 32'h1008, ALU_SRA, SEL_REG_REG, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h0, 1'b0},
	'{32'h00a4d433, 32'h100c, ALU_SRL, SEL_REG_REG, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h0, 1'b0},
	'{32'h011877b3, 32'h1010, ALU_AND, SEL_REG_REG, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h0, 1'b0},
	'{32'hfff10093, 32'h1014, ALU_ADD, SEL_REG_IMM, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'hffffffff, 1'b0},
	'{32'h4032d213, 32'h1018, ALU_SRA, SEL_REG_IMM, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h403, 1'b0},
	'{32'h7ff3c313, 32'h101c, ALU_XOR, SEL_REG_IMM, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h7ff, 1'b0},
	// lui, auipc, jal -8, jalr 4
	'{32'h80001537, 32'h1020, ALU_ADD, SEL_ZERO_IMM, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h80001000, 1'b0},
	'{32'h12345597, 32'h1024, ALU_ADD, SEL_PC_IMM, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h12345000, 1'b0},
	'{32'hff9ff0ef, 32'h1028, ALU_ADD, SEL_PC_IMM, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'hfffffff8, 1'b0},
	'{32'h00408067, 32'h102c, ALU_ADD, SEL_JALR_TGT, BR_NONE, MEM_NONE, EXT_PASS, 1'b1, 32'h4, 1'b0},
	// beq bne blt bge bltu bgeu
	'{32'h00208863, 32'h1030, ALU_ADD, SEL_PC_IMM, BR_EQ, MEM_NONE, EXT_PASS, 1'b0, 32'h10, 1'b0},
	'{32'hfe419ee3, 32'h1034, ALU_ADD, SEL_PC_IMM, BR_NE, MEM_NONE, EXT_PASS, 1'b0, 32'hfffffffc, 1'b0},
	'{32'h0062c463, 32'h1038, ALU_ADD, SEL_PC_IMM, BR_LT, MEM_NONE, EXT_PASS, 1'b0, 32'h8, 1'b0},
	'{32'h0062d463, 32'h103c, ALU_ADD, SEL_PC_IMM, BR_LT, MEM_NONE, EXT_PASS, 1'b0, 32'h8, 1'b1},
	'{32'h0083e463, 32'h1040, ALU_ADD, SEL_PC_IMM, BR_LTU, MEM_NONE, EXT_PASS, 1'b0, 32'h8, 1'b0},
	'{32'h0083f463, 32'h1044, ALU_ADD, SEL_PC_IMM, BR_LTU, MEM_NONE, EXT_PASS, 1'b0, 32'h8, 1'b1},
	// lw lh lhu lb lbu, then sw sh sb
	'{32'h00812603, 32'h1048, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_LD_W, EXT_PASS, 1'b1, 32'h8, 1'b0},
	'{32'hffe19683, 32'h104c, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_LD_H, EXT_SEXT_H, 1'b1, 32'hfffffffe, 1'b0},
	'{32'h0021d683, 32'h1050, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_LD_H, EXT_ZEXT_H, 1'b1, 32'h2, 1'b0},
	'{32'h00120703, 32'h1054, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_LD_B, EXT_SEXT_B, 1'b1, 32'h1, 1'b0},
	'{32'h00124703, 32'h1058, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_LD_B, EXT_ZEXT_B, 1'b1, 32'h1, 1'b0},
	'{32'h00532623, 32'h105c, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_ST_W, EXT_PASS, 1'b0, 32'hc, 1'b0},
	'{32'hfe741e23, 32'h1060, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_ST_H, EXT_PASS, 1'b0, 32'hfffffffc, 1'b0},
	'{32'h009501a3, 32'h1064, ALU_ADD, SEL_MEM_ADDR, BR_NONE, MEM_ST_B, EXT_PASS, 1'b0, 32'h3, 1'b0}
};

`endif

// File: verif/dec_tb.sv
// decode stage testbench
// register preload, decode table loop, pipeline control and register file checks
`timescale 1ns/1ps
`include "dec_config.svh"

module dec_tb import dec_pkg::*; ();

	logic                 clk = 1'b0;
	logic                 rst;
	logic [`DEC_XLEN-1:0] inst;
	logic [`DEC_XLEN-1:0] pc;
	logic                 il1_ack;
	logic                 enb;
	logic                 kill;
	logic                 nop_gen;
	logic                 wb_we;
	logic [4:0]           wb_rd;
	logic [`DEC_XLEN-1:0] wb_data;
	logic                 stall;
	alu_op_e              out_alu_op;
	opnd_sel_e            out_opnd_sel;
	br_cond_e             out_br_cond;
	mem_req_e             out_mem_req;
	ld_ext_e              out_ld_ext;
	logic                 out_reg_we;
	logic [`DEC_XLEN-1:0] out_src1;
	logic [`DEC_XLEN-1:0] out_src2;
	logic [`DEC_XLEN-1:0] out_imm;
	logic [`DEC_XLEN-1:0] out_pc;
	logic [`DEC_XLEN-1:0] out_pc_next;
	logic [14:0]          out_hazard;

	logic [`DEC_XLEN-1:0] shadow [`DEC_NREGS]; // expected register file contents
	int                   seed = 95;
	int                   errors = 0;
	int                   checks = 0;

	`include "dec_tb_table.svh"

	always #4 clk = ~clk; // 8 ns period

	decode_stage decode_stage_inst (.*);

	// ------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------
	task automatic check_alu(input alu_op_e got, input alu_op_e exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s alu_op %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_sel(input opnd_sel_e got, input opnd_sel_e exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s opnd_sel %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_br(input br_cond_e got, input br_cond_e exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s br_cond %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_mem(input mem_req_e got, input mem_req_e exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s mem_req %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_ext(input ld_ext_e got, input ld_ext_e exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s ld_ext %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------
	// sequencing
	// ------------------------------------------------------------
	task automatic finish_run();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic wait_edges(input int n);
		for (int k = 0; k < n; k++)
			@(posedge clk);
	endtask

	// poll the combinational stall at falling edges
	task automatic wait_stall(input logic exp);
		int n;
		n = 0;
		while (stall !== exp && n < 16) begin
			@(negedge clk);
			n++;
		end
		checks++;
		if (stall !== exp) begin
			errors++;
			$display("timeout: stall did not reach %b within 16 cycles of il1_ack changing", exp);
		end
	endtask

	// drive at a rising edge, capture on the next one, sample at the falling edge
	task automatic apply_inst(input logic [31:0] word, input logic [31:0] addr,
		input logic en = 1'b1, input logic kl = 1'b0, input logic nop = 1'b0,
		input logic wr = 1'b0, input logic [4:0] wr_reg = 5'd0,
		input logic [31:0] wr_val = 32'h0);
		wait_edges(1);
		inst    <= word;
		pc      <= addr;
		enb     <= en;
		kill    <= kl;
		nop_gen <= nop;
		wb_we   <= wr;
		wb_rd   <= wr_reg;
		wb_data <= wr_val;
		wait_edges(1);
		@(negedge clk);
	endtask

	initial begin
		logic [31:0] val;
		logic [31:0] exp1;
		logic [31:0] exp2;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		string       tag;

		rst       = 1'b1;
		inst      = '0;
		pc        = '0;
		il1_ack   = 1'b1;
		enb       = 1'b0;
		kill      = 1'b0;
		nop_gen   = 1'b0;
		wb_we     = 1'b0;
		wb_rd     = '0;
		wb_data   = '0;
		shadow[0] = '0;

		wait_edges(2); // reset over two rising edges
		rst <= 1'b0;
		@(negedge clk);
		check_bit(out_reg_we, 1'b0, "reg_we after reset");
		check_mem(out_mem_req, MEM_NONE, "after reset");

		// preload x1..x31 through the write port
		for (int r = 1; r < `DEC_NREGS; r++) begin
			val = $random(seed);
			wait_edges(1);
			wb_we     <= 1'b1;
			wb_rd     <= r[4:0];
			wb_data   <= val;
			shadow[r] = val;
		end
		wait_edges(1);
		wb_we <= 1'b0;

		// ------------------------------------------------------------
		// decode table
		// ------------------------------------------------------------
		for (int i = 0; i < NROWS; i++) begin
			tag = $sformatf("row %0d", i);
			apply_inst(rows[i].word, rows[i].pc);
			rs1  = rows[i].word[19:15];
			rs2  = rows[i].word[24:20];
			exp1 = rows[i].swap ? shadow[rs2] : shadow[rs1]; // bge/bgeu read swapped
			exp2 = rows[i].swap ? shadow[rs1] : shadow[rs2];
			check_alu(out_alu_op, rows[i].alu_op, tag);
			check_sel(out_opnd_sel, rows[i].opnd_sel, tag);
			check_br(out_br_cond, rows[i].br_cond, tag);
			check_mem(out_mem_req, rows[i].mem_req, tag);
			check_ext(out_ld_ext, rows[i].ld_ext, tag);
			check_bit(out_reg_we, rows[i].reg_we, {tag, " reg_we"});
			check_word(out_imm, rows[i].imm, {tag, " imm"});
			check_word(out_src1, exp1, {tag, " src1"});
			check_word(out_src2, exp2, {tag, " src2"});
			check_word(out_pc, rows[i].pc, {tag, " pc"});
			check_word(out_pc_next, rows[i].pc + 32'd4, {tag, " pc_next"});
			check_word({17'b0, out_hazard}, {17'b0, rows[i].word[11:7], rs1, rs2},
				{tag, " hazard"});
		end

		// ------------------------------------------------------------
		// pipeline controls
		// ------------------------------------------------------------
		apply_inst(32'h002081b3, 32'h200); // add
		apply_inst(32'h407302b3, 32'h204, 1'b0); // sub with enable low
		check_alu(out_alu_op, ALU_ADD, "hold");
		check_word(out_pc, 32'h200, "pc on hold");

		apply_inst(32'h00812603, 32'h208, 1'b1, 1'b1); // lw under kill
		check_bit(out_reg_we, 1'b0, "reg_we on kill");
		check_mem(out_mem_req, MEM_NONE, "kill");
		check_sel(out_opnd_sel, SEL_REG_REG, "kill");
		check_word(out_imm, 32'h0, "imm on kill");
		check_word(out_pc, 32'h0, "pc on kill");
		check_word(out_src1, 32'h0, "src1 on kill");

		apply_inst(32'h00812603, 32'h20c, 1'b1, 1'b0, 1'b1); // lw as bubble
		check_bit(out_reg_we, 1'b0, "reg_we on nop_gen");
		check_mem(out_mem_req, MEM_NONE, "nop_gen");
		check_sel(out_opnd_sel, SEL_MEM_ADDR, "nop_gen");
		check_word(out_imm, 32'h8, "imm on nop_gen");
		apply_inst(32'h407302b3, 32'h210, 1'b1, 1'b0, 1'b1);
		check_alu(out_alu_op, ALU_SUB, "nop_gen");
		check_bit(out_reg_we, 1'b0, "sub reg_we on nop_gen");

		wait_edges(1);
		il1_ack <= 1'b0;
		wait_stall(1'b1);
		wait_edges(1);
		il1_ack <= 1'b1;
		wait_stall(1'b0);

		// ------------------------------------------------------------
		// register file
		// ------------------------------------------------------------
		apply_inst(32'h000000b3, 32'h300, 1'b1, 1'b0, 1'b0, 1'b1, 5'd0, 32'hdeadbeef);
		check_word(out_src1, 32'h0, "x0 src1 during write");
		apply_inst(32'h000000b3, 32'h304); // add x1, x0, x0
		check_word(out_src1, 32'h0, "x0 src1 after write");
		check_word(out_src2, 32'h0, "x0 src2 after write");

		val = $random(seed);
		apply_inst(32'h002081b3, 32'h308, 1'b1, 1'b0, 1'b0, 1'b1, 5'd1, val);
		check_word(out_src1, val, "bypassed src1");
		check_word(out_src2, shadow[2], "src2 beside bypass");
		shadow[1] = val;
		apply_inst(32'h002081b3, 32'h30c);
		check_word(out_src1, shadow[1], "src1 after write");

		finish_run();
	end

endmodule

// File: logic/decode_stage.sv
// decode stage top
// control decoder, immediate builder and register file
// decode/execute pipeline register with enable, kill and nop insertion
`timescale 1ns/1ps
`include "dec_config.svh"

module decode_stage import dec_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`DEC_XLEN-1:0] inst,
	input  logic [`DEC_XLEN-1:0] pc,
	input  logic                 il1_ack,
	input  logic                 enb,
	input  logic                 kill,
	input  logic                 nop_gen,
	input  logic                 wb_we,
	input  logic [4:0]           wb_rd,
	input  logic [`DEC_XLEN-1:0] wb_data,
	output logic                 stall,
	output alu_op_e              out_alu_op,
	output opnd_sel_e            out_opnd_sel,
	output br_cond_e             out_br_cond,
	output mem_req_e             out_mem_req,
	output ld_ext_e              out_ld_ext,
	output logic                 out_reg_we,
	output logic [`DEC_XLEN-1:0] out_src1,
	output logic [`DEC_XLEN-1:0] out_src2,
	output logic [`DEC_XLEN-1:0] out_imm,
	output logic [`DEC_XLEN-1:0] out_pc,
	output logic [`DEC_XLEN-1:0] out_pc_next,
	output logic [14:0]          out_hazard
);

	instr_u               inst_w;
	alu_op_e              alu_op;
	opnd_sel_e            opnd_sel;
	br_cond_e             br_cond;
	logic                 order;
	mem_req_e             mem_req;
	ld_ext_e              ld_ext;
	logic                 reg_we;
	imm_kind_e            imm_kind;
	logic [`DEC_XLEN-1:0] imm;
	logic [`DEC_XLEN-1:0] src1;
	logic [`DEC_XLEN-1:0] src2;
	logic [`DEC_XLEN-1:0] pc_next;

	assign inst_w  = inst;
	assign stall   = !il1_ack; // no word from the icache yet
	assign pc_next = pc + `DEC_XLEN'(`DEC_PC_STEP);

	// ------------------------------------------------------------
	// decode blocks
	// ------------------------------------------------------------
	ctrl_decode ctrl_decode_inst (
		.inst     (inst_w),
		.alu_op   (alu_op),
		.opnd_sel (opnd_sel),
		.br_cond  (br_cond),
		.order    (order),
		.mem_req  (mem_req),
		.ld_ext   (ld_ext),
		.reg_we   (reg_we),
		.imm_kind (imm_kind)
	);

	imm_gen imm_gen_inst (
		.inst     (inst_w),
		.imm_kind (imm_kind),
		.imm      (imm)
	);

	reg_file reg_file_inst (
		.clk     (clk),
		.rst     (rst),
		.rs1     (inst_w.r_fmt.rs1),
		.rs2     (inst_w.r_fmt.rs2),
		.wb_rd   (wb_rd),
		.wb_we   (wb_we),
		.wb_data (wb_data),
		.order   (order),
		.src1    (src1),
		.src2    (src2)
	);

	// ------------------------------------------------------------
	// decode/execute register, kill over enable
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || kill) begin
			out_alu_op   <= ALU_ADD;
			out_opnd_sel <= SEL_REG_REG;
			out_br_cond  <= BR_NONE;
			out_mem_req  <= MEM_NONE;
			out_ld_ext   <= EXT_PASS;
			out_reg_we   <= 1'b0;
			out_src1     <= '0;
			out_src2     <= '0;
			out_imm      <= '0;
			out_pc       <= '0;
			out_pc_next  <= '0;
			out_hazard   <= '0;
		end else if (enb) begin
			out_alu_op   <= alu_op;
			out_opnd_sel <= opnd_sel;
			out_br_cond  <= br_cond;
			out_mem_req  <= nop_gen ? MEM_NONE : mem_req; // bubble, no side effects
			out_ld_ext   <= ld_ext;
			out_reg_we   <= reg_we && !nop_gen;
			out_src1     <= src1;
			out_src2     <= src2;
			out_imm      <= imm;
			out_pc       <= pc;
			out_pc_next  <= pc_next;
			out_hazard   <= {inst_w.r_fmt.rd, inst_w.r_fmt.rs1, inst_w.r_fmt.rs2};
		end
	end

endmodule

// File: logic/reg_file.sv
// integer register file, two read ports and one write port
// x0 hardwired to zero, same-cycle write bypass
// read port order swap for bge/bgeu
`timescale 1ns/1ps
`include "dec_config.svh"

module reg_file (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [4:0]           rs1,
	input  logic [4:0]           rs2,
	input  logic [4:0]           wb_rd,
	input  logic                 wb_we,
	input  logic [`DEC_XLEN-1:0] wb_data,
	input  logic                 order,
	output logic [`DEC_XLEN-1:0] src1,
	output logic [`DEC_XLEN-1:0] src2
);

	logic [`DEC_XLEN-1:0] regs [1:`DEC_NREGS-1]; // x0 not stored
	logic                 wr_en;
	logic [`DEC_XLEN-1:0] rd1;
	logic [`DEC_XLEN-1:0] rd2;

	// writes blocked while in reset, contents kept
	assign wr_en = wb_we && !rst && (wb_rd != 5'd0);

	always_ff @(posedge clk) begin
		if (wr_en)
			regs[wb_rd] <= wb_data;
	end

	always_comb begin
		if (rs1 == 5'd0)
			rd1 = '0;
		else if (wr_en && wb_rd == rs1)
			rd1 = wb_data; // bypass
		else
			rd1 = regs[rs1];

		if (rs2 == 5'd0)
			rd2 = '0;
		else if (wr_en && wb_rd == rs2)
			rd2 = wb_data;
		else
			rd2 = regs[rs2];
	end

	assign src1 = order ? rd2 : rd1; // swapped for ge compares
	assign src2 = order ? rd1 : rd2;

endmodule

// File: logic/imm_gen.sv
// immediate builder
// i, s, b, u and j formats, sign extended from instruction bit 31
`timescale 1ns/1ps
`include "dec_config.svh"

module imm_gen import dec_pkg::*; (
	input  instr_u                inst,
	input  imm_kind_e             imm_kind,
	output logic [`DEC_XLEN-1:0] imm
);

	always_comb begin
		case (imm_kind)
			IMM_I: imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
			IMM_S: imm = {{20{inst.s_fmt.imm_11_5[6]}},
				inst.s_fmt.imm_11_5,
				inst.s_fmt.imm_4_0};
			IMM_B: imm = {{19{inst.b_fmt.imm_12}},
				inst.b_fmt.imm_12,
				inst.b_fmt.imm_11,
				inst.b_fmt.imm_10_5,
				inst.b_fmt.imm_4_1,
				1'b0}; // halfword aligned
			IMM_U: imm = {inst.u_fmt.imm_31_12, 12'b0};
			IMM_J: imm = {{11{inst.j_fmt.imm_20}},
				inst.j_fmt.imm_20,
				inst.j_fmt.imm_19_12,
				inst.j_fmt.imm_11,
				inst.j_fmt.imm_10_1,
				1'b0};
			default: imm = '0; // no immediate
		endcase
	end

endmodule

// File: logic/ctrl_decode.sv
// control decoder for rv32i base integer instructions
// opcode, funct3 and funct7 bit 5 to alu, mux, branch, memory controls
// also selects the immediate format for the immediate builder
`timescale 1ns/1ps

module ctrl_decode import dec_pkg::*; (
	input  instr_u    inst,
	output alu_op_e   alu_op,
	output opnd_sel_e opnd_sel,
	output br_cond_e  br_cond,
	output logic      order,
	output mem_req_e  mem_req,
	output ld_ext_e   ld_ext,
	output logic      reg_we,
	output imm_kind_e imm_kind
);

	logic [2:0] funct3;
	logic       alt; // funct7 bit 5, sub / sra select

	assign funct3 = inst.r_fmt.funct3;
	assign alt    = inst.r_fmt.funct7[5];

	// arithmetic op from funct3, sub only allowed for register form
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt_bit,
		input logic sub_ok);
		alu_op_e op;
		case (f3)
			3'b000:  op = (alt_bit && sub_ok) ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		alu_op   = ALU_ADD;
		opnd_sel = SEL_REG_REG;
		br_cond  = BR_NONE;
		order    = 1'b0;
		mem_req  = MEM_NONE;
		ld_ext   = EXT_PASS;
		reg_we   = 1'b0;
		imm_kind = IMM_NONE;

		case (inst.r_fmt.opcode)
			// ------------------------------------------------------------
			// arithmetic
			// ------------------------------------------------------------
			OPC_OP: begin
				alu_op = arith_op(funct3, alt, 1'b1);
				reg_we = 1'b1;
			end
			OPC_OP_IMM: begin
				alu_op   = arith_op(funct3, alt, 1'b0); // srai keeps funct7 bit 5
				opnd_sel = SEL_REG_IMM;
				imm_kind = IMM_I;
				reg_we   = 1'b1;
			end
			OPC_LUI: begin
				opnd_sel = SEL_ZERO_IMM; // 0 + imm
				imm_kind = IMM_U;
				reg_we   = 1'b1;
			end
			OPC_AUIPC: begin
				opnd_sel = SEL_PC_IMM;
				imm_kind = IMM_U;
				reg_we   = 1'b1;
			end
			// ------------------------------------------------------------
			// control transfer
			// ------------------------------------------------------------
			OPC_JAL: begin
				opnd_sel = SEL_PC_IMM;
				imm_kind = IMM_J;
				reg_we   = 1'b1; // link
			end
			OPC_JALR: begin
				opnd_sel = SEL_JALR_TGT;
				imm_kind = IMM_I;
				reg_we   = 1'b1;
			end
			OPC_BRANCH: begin
				opnd_sel = SEL_PC_IMM; // target pc + imm
				imm_kind = IMM_B;
				case (funct3)
					3'b000: br_cond = BR_EQ;
					3'b001: br_cond = BR_NE;
					3'b100: br_cond = BR_LT;
					3'b101: begin
						br_cond = BR_LT; // bge as swapped blt
						order   = 1'b1;
					end
					3'b110: br_cond = BR_LTU;
					3'b111: begin
						br_cond = BR_LTU; // bgeu as swapped bltu
						order   = 1'b1;
					end
					default: br_cond = BR_NONE;
				endcase
			end
			// ------------------------------------------------------------
			// memory
			// ------------------------------------------------------------
			OPC_LOAD: begin
				opnd_sel = SEL_MEM_ADDR;
				imm_kind = IMM_I;
				reg_we   = 1'b1;
				case (funct3)
					3'b000: begin
						mem_req = MEM_LD_B;
						ld_ext  = EXT_SEXT_B;
					end
					3'b001: begin
						mem_req = MEM_LD_H;
						ld_ext  = EXT_SEXT_H;
					end
					3'b010: mem_req = MEM_LD_W;
					3'b100: begin
						mem_req = MEM_LD_B;
						ld_ext  = EXT_ZEXT_B;
					end
					3'b101: begin
						mem_req = MEM_LD_H;
						ld_ext  = EXT_ZEXT_H;
					end
					default: reg_we = 1'b0; // reserved width
				endcase
			end
			OPC_STORE: begin
				opnd_sel = SEL_MEM_ADDR;
				imm_kind = IMM_S;
				case (funct3)
					3'b000:  mem_req = MEM_ST_B;
					3'b001:  mem_req = MEM_ST_H;
					3'b010:  mem_req = MEM_ST_W;
					default: mem_req = MEM_NONE;
				endcase
			end
			default: ; // unknown opcode, defaults stand
		endcase
	end

endmodule

// File: logic/dec_pkg.sv
// decode stage types
// instruction word union with per-format views
// control field enums shared by decoder, immediate builder and top
package dec_pkg;

	// ------------------------------------------------------------
	// major opcodes
	// ------------------------------------------------------------
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_AUIPC  = 7'b0010111,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JALR   = 7'b1100111,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	// ------------------------------------------------------------
	// instruction formats, msb first
	// ------------------------------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_u;

	// ------------------------------------------------------------
	// control fields, zero encoding is the idle value
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_REG_REG, SEL_REG_IMM, SEL_ZERO_IMM, SEL_PC_IMM, SEL_JALR_TGT, SEL_MEM_ADDR
	} opnd_sel_e;

	// ge/geu are lt/ltu with swapped operands
	typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_LTU} br_cond_e;

	typedef enum logic [2:0] {
		MEM_NONE, MEM_LD_W, MEM_LD_H, MEM_LD_B, MEM_ST_W, MEM_ST_H, MEM_ST_B
	} mem_req_e;

	typedef enum logic [2:0] {
		EXT_PASS, EXT_SEXT_H, EXT_ZEXT_H, EXT_SEXT_B, EXT_ZEXT_B
	} ld_ext_e;

	typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;

endpackage

// File: logic/dec_config.svh
// shared sizing for the decode stage
// data width, register count, pc increment
`ifndef DEC_CONFIG_SVH
`define DEC_CONFIG_SVH

// ------------------------------------------------------------
// datapath
// ------------------------------------------------------------

// data and instruction word width
`define DEC_XLEN 32

// architectural registers, x0 included
`define DEC_NREGS 32

// ------------------------------------------------------------
// program counter
// ------------------------------------------------------------

// byte step from one instruction to the next
`define DEC_PC_STEP 4

`endif
